/* src/rv_decode_pkg.sv */
/*
 * RISC-V decode package
 * Field widths, major opcodes, execution classes, per-unit operation codes
 * and immediate formats shared by the decode stage
 */
`default_nettype none

package rv_decode_pkg;

    localparam int ilen     = 32;
    localparam int reg_bits = 5;
    localparam int op_bits  = 4;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_FENCE  = 7'b0001111,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Execution class, NOP for anything not recognized
    typedef enum logic [2:0] {
        EX_NOP,
        EX_ALU,
        EX_BR,
        EX_MUL,
        EX_LSU,
        EX_SFU
    } ex_type_e;

    typedef enum logic [op_bits-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [op_bits-1:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE,
        BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_MRET
    } br_op_e;

    // Same order as func3
    typedef enum logic [op_bits-1:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU,
        MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
    } mul_op_e;

    // Loads and stores use {is_store, func3}
    localparam logic [op_bits-1:0] lsu_op_fence = 4'd15;

    typedef enum logic [op_bits-1:0] {
        SFU_CSRRW = 4'd1,
        SFU_CSRRS = 4'd2,
        SFU_CSRRC = 4'd3
    } sfu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_I_SHAMT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_CSR_Z, // rs1 field as unsigned value
        IMM_PC4    // Return address offset
    } imm_fmt_e;

endpackage

`default_nettype wire

/* src/decoded_op_if.sv */
/*
 * Decoded instruction bundle
 * Carries one decoded word from the decoder to the output register
 */
`timescale 1ns/1ps
`default_nettype none

interface decoded_op_if;
    import rv_decode_pkg::*;

    ex_type_e              ex_type;
    logic [op_bits-1:0]    op_type;
    logic [ilen-1:0]       imm;
    logic                  use_imm;
    logic                  use_pc;
    logic                  wb;
    logic [reg_bits-1:0]   rd;
    logic [reg_bits-1:0]   rs1;
    logic [reg_bits-1:0]   rs2;

    modport decoder (
        output ex_type, op_type, imm, use_imm, use_pc, wb, rd, rs1, rs2
    );

    modport sink (
        input ex_type, op_type, imm, use_imm, use_pc, wb, rd, rs1, rs2
    );

endinterface

`default_nettype wire

/* src/rv_imm_gen.sv */
/*
 * Immediate generator
 * Assembles the 32-bit operand immediate for the selected instruction format
 */
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
    input  wire [rv_decode_pkg::ilen-1:0] instr,
    input  wire rv_decode_pkg::imm_fmt_e  fmt,
    output logic [rv_decode_pkg::ilen-1:0] imm
);
    import rv_decode_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            IMM_I:       imm = {{(ilen-12){sign}}, instr[31:20]};
            IMM_I_SHAMT: imm = {{(ilen-5){1'b0}}, instr[24:20]};
            IMM_S:       imm = {{(ilen-12){sign}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                imm = {{(ilen-13){sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U:       imm = {instr[31:12], 12'b0};
            IMM_J: begin
                // 21-bit jump offset, bit 0 always zero
                imm = {{(ilen-21){sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            IMM_CSR_Z:   imm = {{(ilen-5){1'b0}}, instr[19:15]};
            IMM_PC4:     imm = ilen'(4);
            default:     imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/rv_op_decoder.sv */
/*
 * RV32IM instruction decoder
 * Maps opcode and function fields to execution class, operation,
 * immediate, register use and the warp-stall flag
 */
`timescale 1ns/1ps
`default_nettype none

module rv_op_decoder (
    input  wire [rv_decode_pkg::ilen-1:0] instr,
    decoded_op_if.decoder                 op,
    output logic                          wstall
);
    import rv_decode_pkg::*;

    opcode_e               opcode;
    logic [2:0]            func3;
    logic [6:0]            func7;
    logic [reg_bits-1:0]   rd, rs1, rs2;
    logic [11:0]           imm12;

    alu_op_e               alu_sel;
    br_op_e                br_sel;
    br_op_e                ret_sel;
    mul_op_e               mul_sel;
    sfu_op_e               sfu_sel;
    logic                  br_ok;
    logic                  ret_ok;

    ex_type_e              ex_type;
    logic [op_bits-1:0]    op_type;
    imm_fmt_e              fmt;
    logic                  use_imm, use_pc, use_rd;
    logic [reg_bits-1:0]   rd_r, rs1_r, rs2_r;
    logic [ilen-1:0]       imm;

    assign opcode = opcode_e'(instr[6:0]);
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign imm12  = instr[31:20];

    assign mul_sel = mul_op_e'({1'b0, func3});
    assign sfu_sel = sfu_op_e'({2'b00, func3[1:0]});
    assign br_ok   = (func3[2:1] != 2'b01); // func3 2 and 3 are reserved

    always_comb begin
        case (func3)
            3'd0:    alu_sel = (opcode == OPC_OP && func7[5]) ? ALU_SUB : ALU_ADD;
            3'd1:    alu_sel = ALU_SLL;
            3'd2:    alu_sel = ALU_SLT;
            3'd3:    alu_sel = ALU_SLTU;
            3'd4:    alu_sel = ALU_XOR;
            3'd5:    alu_sel = func7[5] ? ALU_SRA : ALU_SRL;
            3'd6:    alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    end

    always_comb begin
        case (func3)
            3'd1:    br_sel = BR_NE;
            3'd4:    br_sel = BR_LT;
            3'd5:    br_sel = BR_GE;
            3'd6:    br_sel = BR_LTU;
            3'd7:    br_sel = BR_GEU;
            default: br_sel = BR_EQ;
        endcase
    end

    // System returns, keyed on the funct12 field
    always_comb begin
        ret_ok = 1'b1;
        case (imm12)
            12'h000: ret_sel = BR_ECALL;
            12'h001: ret_sel = BR_EBREAK;
            12'h302: ret_sel = BR_MRET;
            default: begin
                ret_sel = BR_ECALL;
                ret_ok  = 1'b0;
            end
        endcase
    end

    always_comb begin
        ex_type = EX_NOP;
        op_type = '0;
        fmt     = IMM_I;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        use_rd  = 1'b0;
        rd_r    = '0;
        rs1_r   = '0;
        rs2_r   = '0;
        wstall  = 1'b0;

        case (opcode)
            OPC_OP_IMM: begin
                ex_type = EX_ALU;
                op_type = alu_sel;
                fmt     = (func3[1:0] == 2'b01) ? IMM_I_SHAMT : IMM_I;
                use_imm = 1'b1;
                use_rd  = 1'b1;
                rd_r    = rd;
                rs1_r   = rs1;
            end
            OPC_OP: begin
                ex_type = (func7 == 7'b0000001) ? EX_MUL : EX_ALU;
                op_type = (func7 == 7'b0000001) ? mul_sel : alu_sel;
                use_rd  = 1'b1;
                rd_r    = rd;
                rs1_r   = rs1;
                rs2_r   = rs2;
            end
            OPC_LUI, OPC_AUIPC: begin
                ex_type = EX_ALU;
                op_type = opcode[5] ? ALU_LUI : ALU_AUIPC;
                fmt     = IMM_U;
                use_imm = 1'b1;
                use_pc  = ~opcode[5];
                use_rd  = 1'b1;
                rd_r    = rd;
            end
            OPC_JAL: begin
                ex_type = EX_BR;
                op_type = BR_JAL;
                fmt     = IMM_J;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                use_rd  = 1'b1;
                rd_r    = rd;
                wstall  = 1'b1;
            end
            OPC_JALR: begin
                ex_type = EX_BR;
                op_type = BR_JALR;
                use_imm = 1'b1;
                use_rd  = 1'b1;
                rd_r    = rd;
                rs1_r   = rs1;
                wstall  = 1'b1;
            end
            OPC_BRANCH: begin
                if (br_ok) begin
                    ex_type = EX_BR;
                    op_type = br_sel;
                    fmt     = IMM_B;
                    use_imm = 1'b1;
                    use_pc  = 1'b1;
                    rs1_r   = rs1;
                    rs2_r   = rs2;
                    wstall  = 1'b1;
                end
            end
            OPC_LOAD, OPC_STORE: begin
                ex_type = EX_LSU;
                op_type = {opcode[5], func3}; // Store bit on top
                fmt     = opcode[5] ? IMM_S : IMM_I;
                use_imm = 1'b1;
                use_rd  = ~opcode[5];
                rd_r    = opcode[5] ? '0 : rd;
                rs1_r   = rs1;
                rs2_r   = opcode[5] ? rs2 : '0;
            end
            OPC_FENCE: begin
                ex_type = EX_LSU;
                op_type = lsu_op_fence;
            end
            OPC_SYSTEM: begin
                if (func3[1:0] != 2'b00) begin
                    // CSR access, register form keeps the address in imm
                    ex_type = EX_SFU;
                    op_type = sfu_sel;
                    fmt     = func3[2] ? IMM_CSR_Z : IMM_I;
                    use_imm = func3[2];
                    use_rd  = 1'b1;
                    rd_r    = rd;
                    rs1_r   = func3[2] ? '0 : rs1;
                    wstall  = (imm12 <= 12'h003);
                end else if (func3 == 3'd0 && ret_ok) begin
                    ex_type = EX_BR;
                    op_type = ret_sel;
                    fmt     = IMM_PC4;
                    use_imm = 1'b1;
                    use_pc  = 1'b1;
                    use_rd  = 1'b1;
                    rd_r    = rd;
                    wstall  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    rv_imm_gen i_imm_gen (
        .instr (instr),
        .fmt   (fmt),
        .imm   (imm)
    );

    assign op.ex_type = ex_type;
    assign op.op_type = op_type;
    assign op.imm     = imm;
    assign op.use_imm = use_imm;
    assign op.use_pc  = use_pc;
    assign op.wb      = use_rd && (rd_r != '0); // x0 is never written
    assign op.rd      = rd_r;
    assign op.rs1     = rs1_r;
    assign op.rs2     = rs2_r;

endmodule

`default_nettype wire

/* src/rv_decode_buf.sv */
/*
 * Decode output register
 * Single-entry valid/ready stage holding warp id, PC and decoded fields
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decode_buf #(
    parameter int num_warps = 4,
    localparam int wid_bits = (num_warps > 1) ? $clog2(num_warps) : 1
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   in_valid,
    output logic                                  in_ready,
    input  wire [wid_bits-1:0]                    in_wid,
    input  wire [rv_decode_pkg::ilen-1:0]         in_pc,
    decoded_op_if.sink                            op,
    output logic                                  out_valid,
    input  wire                                   out_ready,
    output logic [wid_bits-1:0]                   wid,
    output logic [rv_decode_pkg::ilen-1:0]        pc,
    output rv_decode_pkg::ex_type_e               ex_type,
    output logic [rv_decode_pkg::op_bits-1:0]     op_type,
    output logic [rv_decode_pkg::ilen-1:0]        imm,
    output logic                                  use_imm,
    output logic                                  use_pc,
    output logic                                  wb,
    output logic [rv_decode_pkg::reg_bits-1:0]    rd,
    output logic [rv_decode_pkg::reg_bits-1:0]    rs1,
    output logic [rv_decode_pkg::reg_bits-1:0]    rs2
);

    logic load;

    assign in_ready = ~out_valid || out_ready; // Empty or draining this cycle
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wid     <= in_wid;
            pc      <= in_pc;
            ex_type <= op.ex_type;
            op_type <= op.op_type;
            imm     <= op.imm;
            use_imm <= op.use_imm;
            use_pc  <= op.use_pc;
            wb      <= op.wb;
            rd      <= op.rd;
            rs1     <= op.rs1;
            rs2     <= op.rs2;
        end
    end

endmodule

`default_nettype wire

/* src/rv_decode_top.sv */
/*
 * Instruction decode stage
 * Decodes fetched words into a registered output and notifies the
 * warp scheduler when an accepted word must stall its warp
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top #(
    parameter int num_warps = 4,
    localparam int wid_bits = (num_warps > 1) ? $clog2(num_warps) : 1
) (
    input  wire                                   clk,
    input  wire                                   rst_n,

    input  wire                                   fetch_valid,
    output logic                                  fetch_ready,
    input  wire [wid_bits-1:0]                    fetch_wid,
    input  wire [rv_decode_pkg::ilen-1:0]         fetch_pc,
    input  wire [rv_decode_pkg::ilen-1:0]         fetch_instr,

    output logic                                  dec_valid,
    input  wire                                   dec_ready,
    output logic [wid_bits-1:0]                   dec_wid,
    output logic [rv_decode_pkg::ilen-1:0]        dec_pc,
    output rv_decode_pkg::ex_type_e               dec_ex_type,
    output logic [rv_decode_pkg::op_bits-1:0]     dec_op_type,
    output logic [rv_decode_pkg::ilen-1:0]        dec_imm,
    output logic                                  dec_use_imm,
    output logic                                  dec_use_pc,
    output logic                                  dec_wb,
    output logic [rv_decode_pkg::reg_bits-1:0]    dec_rd,
    output logic [rv_decode_pkg::reg_bits-1:0]    dec_rs1,
    output logic [rv_decode_pkg::reg_bits-1:0]    dec_rs2,

    output logic                                  sched_valid,
    output logic [wid_bits-1:0]                   sched_wid,
    output logic                                  sched_wstall
);

    decoded_op_if dec_op ();

    logic wstall;

    rv_op_decoder i_decoder (
        .instr  (fetch_instr),
        .op     (dec_op.decoder),
        .wstall (wstall)
    );

    rv_decode_buf #(
        .num_warps (num_warps)
    ) i_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_wid    (fetch_wid),
        .in_pc     (fetch_pc),
        .op        (dec_op.sink),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .wid       (dec_wid),
        .pc        (dec_pc),
        .ex_type   (dec_ex_type),
        .op_type   (dec_op_type),
        .imm       (dec_imm),
        .use_imm   (dec_use_imm),
        .use_pc    (dec_use_pc),
        .wb        (dec_wb),
        .rd        (dec_rd),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2)
    );

    // Scheduler sees the word in its accept cycle
    assign sched_valid  = fetch_valid && fetch_ready;
    assign sched_wid    = fetch_wid;
    assign sched_wstall = wstall;

endmodule

`default_nettype wire

/* dv/tb_rv_decode_ref.svh */
/*
 * Decode stage testbench reference
 * Expected-result record, LFSR stepping and the reference decode rules
 */
`ifndef TB_RV_DECODE_REF_SVH
`define TB_RV_DECODE_REF_SVH

typedef struct packed {
    logic [2:0]  ex_type;
    logic [3:0]  op_type;
    logic [31:0] imm;
    logic        use_imm;
    logic        use_pc;
    logic        wb;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        wstall;
    logic [4:0]  wid;
    logic [31:0] pc;
} exp_dec_t;

logic [31:0] lfsr_q = 32'hf59f_d62d;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        r = {r[30:0], lfsr_q[0]};
    end
    return r;
endfunction

// ALU numbering, alt picks SUB or SRA
function automatic logic [3:0] alu_code(logic [2:0] f3, logic alt);
    case (f3)
        3'd0:    return alt ? 4'd1 : 4'd0;
        3'd1:    return 4'd2;
        3'd2:    return 4'd3;
        3'd3:    return 4'd4;
        3'd4:    return 4'd5;
        3'd5:    return alt ? 4'd7 : 4'd6;
        3'd6:    return 4'd8;
        default: return 4'd9;
    endcase
endfunction

function automatic exp_dec_t ref_decode(logic [31:0] w);
    exp_dec_t   e;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [11:0] i12;
    logic       use_rd;
    opc = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    i12 = w[31:20];
    e = '0;
    use_rd = 1'b0;
    e.imm = {{20{w[31]}}, i12}; // I format unless another applies
    case (opc)
        OPC_OP_IMM: begin
            e.ex_type = EX_ALU;
            e.op_type = alu_code(f3, f3 == 3'd5 && f7[5]);
            if (f3 == 3'd1 || f3 == 3'd5)
                e.imm = {27'b0, w[24:20]};
            e.use_imm = 1'b1;
            use_rd = 1'b1;
            e.rs1 = w[19:15];
        end
        OPC_OP: begin
            e.ex_type = (f7 == 7'd1) ? EX_MUL : EX_ALU;
            e.op_type = (f7 == 7'd1) ? {1'b0, f3} : alu_code(f3, f7[5]);
            use_rd = 1'b1;
            e.rs1 = w[19:15];
            e.rs2 = w[24:20];
        end
        OPC_LUI, OPC_AUIPC: begin
            e.ex_type = EX_ALU;
            e.op_type = (opc == OPC_LUI) ? 4'd10 : 4'd11;
            e.imm = {w[31:12], 12'b0};
            e.use_imm = 1'b1;
            e.use_pc = (opc == OPC_AUIPC);
            use_rd = 1'b1;
        end
        OPC_JAL: begin
            e.ex_type = EX_BR;
            e.op_type = 4'd6;
            e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            e.use_imm = 1'b1;
            e.use_pc = 1'b1;
            use_rd = 1'b1;
            e.wstall = 1'b1;
        end
        OPC_JALR: begin
            e.ex_type = EX_BR;
            e.op_type = 4'd7;
            e.use_imm = 1'b1;
            use_rd = 1'b1;
            e.rs1 = w[19:15];
            e.wstall = 1'b1;
        end
        OPC_BRANCH: begin
            if (f3 != 3'd2 && f3 != 3'd3) begin
                e.ex_type = EX_BR;
                e.op_type = (f3 < 3'd2) ? {3'b0, f3[0]} : {1'b0, f3} - 4'd2;
                e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                e.use_imm = 1'b1;
                e.use_pc = 1'b1;
                e.rs1 = w[19:15];
                e.rs2 = w[24:20];
                e.wstall = 1'b1;
            end
        end
        OPC_LOAD: begin
            e.ex_type = EX_LSU;
            e.op_type = {1'b0, f3};
            e.use_imm = 1'b1;
            use_rd = 1'b1;
            e.rs1 = w[19:15];
        end
        OPC_STORE: begin
            e.ex_type = EX_LSU;
            e.op_type = {1'b1, f3};
            e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            e.use_imm = 1'b1;
            e.rs1 = w[19:15];
            e.rs2 = w[24:20];
        end
        OPC_FENCE: begin
            e.ex_type = EX_LSU;
            e.op_type = 4'd15;
        end
        OPC_SYSTEM: begin
            if (f3[1:0] != 2'b00) begin
                e.ex_type = EX_SFU;
                e.op_type = {2'b00, f3[1:0]};
                if (f3[2]) begin
                    e.imm = {27'b0, w[19:15]};
                    e.use_imm = 1'b1;
                end else begin
                    e.rs1 = w[19:15];
                end
                use_rd = 1'b1;
                e.wstall = (i12 <= 12'h003); // Low CSR addresses stall
            end else if (f3 == 3'd0 && (i12 == 12'h000 || i12 == 12'h001 ||
                                        i12 == 12'h302)) begin
                e.ex_type = EX_BR;
                e.op_type = (i12 == 12'h302) ? 4'd10 : 4'd8 + {3'b0, i12[0]};
                e.imm = 32'd4;
                e.use_imm = 1'b1;
                e.use_pc = 1'b1;
                use_rd = 1'b1;
                e.wstall = 1'b1;
            end
        end
        default: ;
    endcase
    e.rd = use_rd ? w[11:7] : 5'd0;
    e.wb = use_rd && (w[11:7] != 5'd0);
    return e;
endfunction

`endif

/* dv/tb_rv_decode.sv */
/*
 * Decode stage testbench
 * Directed and random words, random back-pressure, reference comparison
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode;
    import rv_decode_pkg::*;

    `include "tb_rv_decode_ref.svh"

    localparam int num_warps = 4;
    localparam int n_random  = 400;

    logic clk = 1'b0;
    logic rst_n, fetch_valid, fetch_ready, dec_valid, dec_ready;
    logic [1:0] fetch_wid, dec_wid, sched_wid;
    logic [31:0] fetch_pc, fetch_instr, dec_pc, dec_imm;
    ex_type_e dec_ex_type;
    logic [3:0] dec_op_type;
    logic dec_use_imm, dec_use_pc, dec_wb, sched_valid, sched_wstall;
    logic [4:0] dec_rd, dec_rs1, dec_rs2;

    logic [31:0] words[$];
    exp_dec_t exp_q[$];
    exp_dec_t snap;
    bit words_ready = 1'b0;
    bit bp_on = 1'b0;
    bit held = 1'b0;
    int out_count = 0;
    string test_name = "reset";

    rv_decode_top #(.num_warps(num_warps)) i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] enc(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    task automatic build_directed();
        logic [4:0] rdv;
        logic [11:0] addr;
        for (int k = 0; k < 2; k++) begin
            rdv = (k == 0) ? 5'd0 : 5'd17;
            for (int f = 0; f < 8; f++) begin
                words.push_back(enc(7'h00, 5'd9, 5'd1, 3'(f), rdv, OPC_OP_IMM));
                words.push_back(enc(7'h00, 5'd4, 5'd2, 3'(f), rdv, OPC_OP));
                words.push_back(enc(7'h01, 5'd5, 5'd3, 3'(f), rdv, OPC_OP));
                words.push_back(enc(7'h4b, 5'd7, 5'd6, 3'(f), rdv, OPC_BRANCH));
                words.push_back(enc(7'h7e, 5'd3, 5'd8, 3'(f), rdv, OPC_LOAD));
                if (f < 3)
                    words.push_back(enc(7'h41, 5'd2, 5'd8, 3'(f), rdv, OPC_STORE));
                for (int a = 0; a < 2; a++) begin
                    addr = (a == 0) ? 12'h003 : 12'h004;
                    if (f != 0 && f != 4)
                        words.push_back(enc(addr[11:5], addr[4:0], 5'd12, 3'(f), rdv,
                                            OPC_SYSTEM));
                end
            end
            words.push_back(enc(7'h20, 5'd3, 5'd2, 3'd5, rdv, OPC_OP_IMM)); // SRAI
            words.push_back(enc(7'h7f, 5'd1, 5'd2, 3'd0, rdv, OPC_OP_IMM));
            words.push_back(enc(7'h20, 5'd3, 5'd2, 3'd0, rdv, OPC_OP));
            words.push_back(enc(7'h20, 5'd3, 5'd2, 3'd5, rdv, OPC_OP));
            words.push_back(enc(7'h5a, 5'd3, 5'd2, 3'd1, rdv, OPC_LUI));
            words.push_back(enc(7'h5a, 5'd3, 5'd2, 3'd1, rdv, OPC_AUIPC));
            words.push_back(enc(7'h65, 5'd13, 5'd2, 3'd6, rdv, OPC_JAL));
            words.push_back(enc(7'h70, 5'd1, 5'd2, 3'd0, rdv, OPC_JALR));
            words.push_back(enc(7'h00, 5'd0, 5'd0, 3'd0, rdv, OPC_FENCE));
            words.push_back(enc(7'h00, 5'd0, 5'd0, 3'd0, rdv, OPC_SYSTEM));
            words.push_back(enc(7'h00, 5'd1, 5'd0, 3'd0, rdv, OPC_SYSTEM));
            words.push_back(enc(7'h18, 5'd2, 5'd0, 3'd0, rdv, OPC_SYSTEM));
            words.push_back(enc(7'h08, 5'd5, 5'd0, 3'd0, rdv, OPC_SYSTEM)); // WFI
            words.push_back(enc(7'h15, 5'd6, 5'd7, 3'd2, rdv, 7'b0101011));
        end
    endtask

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        logic [3:0] sel;
        w = take_bits(32);
        sel = 4'(take_bits(4));
        case (sel)
            4'd0:  w[6:0] = OPC_LOAD;
            4'd1:  w[6:0] = OPC_STORE;
            4'd2:  w[6:0] = OPC_FENCE;
            4'd3:  w[6:0] = OPC_LUI;
            4'd4:  w[6:0] = OPC_AUIPC;
            4'd5:  w[6:0] = OPC_JAL;
            4'd6:  w[6:0] = OPC_JALR;
            4'd7:  w[6:0] = OPC_BRANCH;
            4'd8, 4'd9: begin
                w[6:0] = OPC_OP_IMM;
                if (w[13:12] == 2'b01)
                    w[31:25] = {1'b0, w[30], 5'b0};
            end
            4'd10, 4'd11: begin
                w[6:0] = OPC_OP;
                w[31:25] = w[25] ? 7'h01 : {1'b0, w[30] && !w[13], 5'b0};
            end
            4'd12, 4'd13: begin
                w[6:0] = OPC_SYSTEM;
                if (take_bits(1) == 1)
                    w[31:20] = (take_bits(1) == 1) ? 12'h302 : 12'(take_bits(3));
            end
            default: w[1:0] = 2'b00; // No kept opcode
        endcase
        return w;
    endfunction

    function automatic exp_dec_t out_record();
        exp_dec_t r;
        r = '0;
        r.ex_type = dec_ex_type;
        r.op_type = dec_op_type;
        r.imm = dec_imm;
        r.use_imm = dec_use_imm;
        r.use_pc = dec_use_pc;
        r.wb = dec_wb;
        r.rd = dec_rd;
        r.rs1 = dec_rs1;
        r.rs2 = dec_rs2;
        r.wid = {3'b0, dec_wid};
        r.pc = dec_pc;
        return r;
    endfunction

    task automatic check_value(string what, logic [127:0] expv, logic [127:0] actv);
        assert (expv == actv) else begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expv, actv);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_word(int idx);
        bit taken;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_instr = words[idx];
        fetch_wid = 2'(idx % num_warps);
        fetch_pc = 32'h1000 + 32'(idx) * 4;
        do begin
            #10;
            taken = fetch_ready;
            if (!taken)
                @(negedge clk);
        end while (!taken);
    endtask

    always @(negedge clk)
        dec_ready = bp_on ? (take_bits(2) != 0) : 1'b1;

    // Samples halfway through the low phase, ahead of the next rising edge
    always @(negedge clk) begin
        exp_dec_t e;
        exp_dec_t got;
        #10;
        if (rst_n) begin
            got = out_record();
            if (held) begin
                check_value("dec_valid held", 1, dec_valid);
                check_value("held fields", snap, got);
            end
            held = dec_valid && !dec_ready;
            snap = got;
            if (fetch_valid && (!dec_valid || dec_ready))
                check_value("fetch_ready", 1, fetch_ready);
            else if (fetch_valid)
                check_value("fetch_ready stalled", 0, fetch_ready);
            if (dec_valid && dec_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("Output word appeared with no word accepted for it");
                    $display("TB FAILED");
                    $fatal(1, "extra output");
                end
                e = exp_q.pop_front();
                check_value("ex_type", e.ex_type, got.ex_type);
                check_value("op_type", e.op_type, got.op_type);
                check_value("imm", e.imm, got.imm);
                check_value("flags", {e.use_imm, e.use_pc, e.wb},
                            {got.use_imm, got.use_pc, got.wb});
                check_value("regs", {e.rd, e.rs1, e.rs2}, {got.rd, got.rs1, got.rs2});
                check_value("wid/pc", {e.wid, e.pc}, {got.wid, got.pc});
                out_count++;
            end
            if (fetch_valid && fetch_ready) begin
                e = ref_decode(fetch_instr);
                e.wid = {3'b0, fetch_wid};
                e.pc = fetch_pc;
                check_value("sched_valid", 1, sched_valid);
                check_value("sched_wid", fetch_wid, sched_wid);
                check_value("sched_wstall", e.wstall, sched_wstall);
                exp_q.push_back(e);
            end else begin
                check_value("sched_valid idle", 0, sched_valid);
            end
        end
    end

    initial begin
        int n_dir;
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_wid = '0;
        fetch_pc = '0;
        fetch_instr = '0;
        dec_ready = 1'b1;
        build_directed();
        n_dir = words.size();
        for (int i = 0; i < n_random; i++)
            words.push_back(random_word());
        words_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #10;
        check_value("dec_valid after reset", 0, dec_valid);
        test_name = "directed";
        for (int i = 0; i < n_dir; i++)
            send_word(i);
        test_name = "random";
        bp_on = 1'b1;
        for (int i = n_dir; i < words.size(); i++)
            send_word(i);
        @(negedge clk);
        fetch_valid = 1'b0;
        wait (out_count == words.size());
        @(negedge clk);
        #10;
        if (exp_q.size() == 0 && !dec_valid) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Words left over after the last output");
            $display("TB FAILED");
            $fatal(1, "leftover words");
        end
    end

    // Four clock periods per word plus a margin
    initial begin
        wait (words_ready);
        #((words.size() + 10) * 40 * 4 + 2000);
        $display("Timeout: not all words came out of the decode stage");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+dv
src/rv_decode_pkg.sv
src/decoded_op_if.sv
src/rv_imm_gen.sv
src/rv_op_decoder.sv
src/rv_decode_buf.sv
src/rv_decode_top.sv
dv/tb_rv_decode.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_rv_decode -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^TB PASSED$" sim.log
